//--- hazardChecker.sv
// checker for the hazard unit
// operand read pattern, stall and forward model per operand
// expected pcNop and the next decode instruction
// comparison of every DUT output with error and check counts
module hazardChecker
    import isaPkg::*, hazardPkg::*;
(
    input  logic         clk,
    input  logic         arstN,
    input  instWord      fetchInst,
    input  stageWriteT   stageD,
    input  stageWriteT   stageX,
    input  stageWriteT   stageM,
    input  wbSelE        wbSelD,
    input  wbSelE        wbSelX,
    input  branchShadowT branchShadow,
    input  logic         pcNop,
    input  fwdCtrlT      fwdA,
    input  fwdCtrlT      fwdB,
    input  instWord      decodeInst,
    output int           errCount,
    output int           checkCount,
    output int           cycleCount
);

    timeunit 1ns;
    timeprecision 1ps;

    // what the decode register should show at the next sample
    instWord expDecode;

    initial begin
        errCount   = 0;
        checkCount = 0;
        cycleCount = 0;
        expDecode  = NopInst;
    end

    // registers read per opcode class
    function automatic operandUseT expectedUse(logic [4:0] op);
        operandUseT u;
        u.readsRs      = 1'b1;
        u.readsSecond  = 1'b0;
        u.honorsShadow = 1'b1;
        case (op)
            // no register read at all
            opHalt, opNop, opLbi, opJ, opJal: begin
                u.readsRs = 1'b0;
            end
            // exempt from the branch shadow
            opSiic, opRti: begin
                u.readsRs      = 1'b0;
                u.honorsShadow = 1'b0;
            end
            // stores and the register forms read two fields
            opSt, opStu, opBitR, opAluR, opSeq, opSlt, opSle, opSco: begin
                u.readsSecond = 1'b1;
            end
            // branches, jr, jalr and unlisted codes keep rs only
            default: begin
            end
        endcase
        return u;
    endfunction

    // producer writes this register
    function automatic logic hits(stageWriteT s, regIdx r);
        return s.regWrt && (s.wrtReg == r);
    endfunction

    function automatic logic expectedStall(logic used, regIdx r);
        logic loadUse;
        loadUse = hits(stageD, r) && (wbSelD == wbMem);
        return used && (hits(stageM, r) || loadUse);
    endfunction

    // D producer first, load in D blocks every forward
    function automatic fwdCtrlT expectedFwd(logic used, regIdx r);
        fwdCtrlT f;
        f = '0;
        if (used && hits(stageD, r)) begin
            if (wbSelD != wbMem) begin
                f.fwd     = 1'b1;
                f.fromMem = 1'b0;
                f.src     = wbSelD;
            end
        end else if (used && hits(stageX, r)) begin
            f.fwd     = 1'b1;
            f.fromMem = 1'b1;
            f.src     = wbSelX;
        end
        return f;
    endfunction

    task automatic compareValue(string name, logic [15:0] exp, logic [15:0] act);
        checkCount++;
        if (exp !== act) begin
            errCount++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // inputs change 2 ns after the rising edge, falling edge is quiet
    always @(negedge clk) begin
        operandUseT u;
        logic       stA;
        logic       stB;
        logic       expPcNop;
        regIdx      rs;
        regIdx      second;
        if (!arstN) begin
            // nothing issues while in reset
            compareValue("decodeInst", NopInst, decodeInst);
            expDecode = NopInst;
        end else begin
            compareValue("decodeInst", expDecode, decodeInst);
            u        = expectedUse(fetchInst[OpcodeMsb:OpcodeLsb]);
            rs       = fetchInst[RsMsb:RsLsb];
            second   = fetchInst[SecondMsb:SecondLsb];
            stA      = expectedStall(u.readsRs, rs);
            stB      = expectedStall(u.readsSecond, second);
            expPcNop = stA || stB || (u.honorsShadow && (branchShadow != '0));
            compareValue("pcNop", 16'(expPcNop), 16'(pcNop));
            compareValue("fwdA", 16'(expectedFwd(u.readsRs, rs)), 16'(fwdA));
            compareValue("fwdB", 16'(expectedFwd(u.readsSecond, second)), 16'(fwdB));
            // held fetch turns into a bubble
            expDecode = expPcNop ? NopInst : fetchInst;
            cycleCount++;
        end
    end

endmodule

//--- hazardPkg.sv
// pipeline hazard bundles shared by the hazard unit
// producer write info per stage
// branch occupancy of the later stages
// forwarding control word per operand
// operand read pattern of the fetched opcode
package hazardPkg;

    import isaPkg::*;

    // one producer in flight
    typedef struct packed {
        // stage will write the register file
        logic  regWrt;
        // destination register
        regIdx wrtReg;
    } stageWriteT;

    // a branch sits in this stage
    typedef struct packed {
        logic inD;
        logic inX;
        logic inM;
        logic inW;
    } branchShadowT;

    // forwarding control for one source operand
    // all zero when nothing is forwarded
    typedef struct packed {
        // take a forwarded value
        logic  fwd;
        // 0 execute-to-execute, 1 memory-to-execute
        logic  fromMem;
        // which result of the producer to forward
        wbSelE src;
    } fwdCtrlT;

    // registers read by the fetched instruction
    typedef struct packed {
        // reads the rs field
        logic readsRs;
        // reads the rt or rd field
        logic readsSecond;
        // must wait out a branch in flight
        logic honorsShadow;
    } operandUseT;

endpackage

//--- hazardUnit.sv
// hazard unit top level
// opcode classifier, one hazard check per source operand
// and issue control with the fetch-to-decode register
module hazardUnit
    import isaPkg::*, hazardPkg::*;
(
    input  logic         clk,
    input  logic         arstN,

    // instruction from fetch
    input  instWord      fetchInst,

    // producers in flight
    input  stageWriteT   stageD,
    input  stageWriteT   stageX,
    input  stageWriteT   stageM,

    // writeback source of the D and X producers
    input  wbSelE        wbSelD,
    input  wbSelE        wbSelX,

    // branches in the later stages
    input  branchShadowT branchShadow,

    // hold the pc
    output logic         pcNop,

    // forwarding control per operand
    output fwdCtrlT      fwdA,
    output fwdCtrlT      fwdB,

    // instruction entering decode
    output instWord      decodeInst
);

    operandUseT opUse;
    logic       stallA;
    logic       stallB;

    // which fields the fetched opcode reads
    opcodeDecode iOpcodeDecode (
        .inst  (fetchInst),
        .opUse (opUse)
    );

    // operand A, always the rs field
    operandHazard iOperandA (
        .used   (opUse.readsRs),
        .srcReg (fetchInst[RsMsb:RsLsb]),
        .stageD (stageD),
        .stageX (stageX),
        .stageM (stageM),
        .wbSelD (wbSelD),
        .wbSelX (wbSelX),
        .stall  (stallA),
        .fwd    (fwdA)
    );

    // operand B, rd for stores and rt otherwise
    operandHazard iOperandB (
        .used   (opUse.readsSecond),
        .srcReg (fetchInst[SecondMsb:SecondLsb]),
        .stageD (stageD),
        .stageX (stageX),
        .stageM (stageM),
        .wbSelD (wbSelD),
        .wbSelX (wbSelX),
        .stall  (stallB),
        .fwd    (fwdB)
    );

    // stall merge and decode register
    issueControl iIssueControl (
        .clk          (clk),
        .arstN        (arstN),
        .fetchInst    (fetchInst),
        .stallA       (stallA),
        .stallB       (stallB),
        .honorsShadow (opUse.honorsShadow),
        .branchShadow (branchShadow),
        .pcNop        (pcNop),
        .decodeInst   (decodeInst)
    );

endmodule

//--- isaPkg.sv
// instruction set definitions for the 16-bit teaching processor
// instruction word and register index types
// opcode enum, including the set and branch families
// writeback source enum used by the forwarding paths
// instruction field positions and the NOP encoding
package isaPkg;

    // one instruction word
    typedef logic [15:0] instWord;

    // register file index, eight registers
    typedef logic [2:0] regIdx;

    // major opcode in bits 15:11
    // codes not listed here are still legal and decode as rs readers
    typedef enum logic [4:0] {
        // system and no-ops
        opHalt = 5'b00000,
        opNop  = 5'b00001,
        opSiic = 5'b00010,
        opRti  = 5'b00011,
        // jumps, register forms read rs
        opJ    = 5'b00100,
        opJr   = 5'b00101,
        opJal  = 5'b00110,
        opJalr = 5'b00111,
        // conditional branches on rs
        opBeqz = 5'b01100,
        opBnez = 5'b01101,
        opBltz = 5'b01110,
        opBgez = 5'b01111,
        // stores read rs for the address and rd for the data
        opSt   = 5'b10000,
        opStu  = 5'b10011,
        // load immediate, no register read
        opLbi  = 5'b11000,
        // register-register forms
        opBitR = 5'b11010,
        opAluR = 5'b11011,
        // set family
        opSeq  = 5'b11100,
        opSlt  = 5'b11101,
        opSle  = 5'b11110,
        opSco  = 5'b11111
    } opcodeE;

    // where a producer's writeback value comes from
    // also picks the forwarding data source
    typedef enum logic [1:0] {
        wbSlbi = 2'b00,
        wbMem  = 2'b01,
        wbAlu  = 2'b10,
        wbImm  = 2'b11
    } wbSelE;

    // opcode field
    localparam int OpcodeMsb = 15;
    localparam int OpcodeLsb = 11;

    // first source register
    localparam int RsMsb = 10;
    localparam int RsLsb = 8;

    // second register field
    // rd for stores, rt for the register forms
    localparam int SecondMsb = 7;
    localparam int SecondLsb = 5;

    // bubble inserted on a stall, opcode NOP with zero operands
    localparam instWord NopInst = {5'b00001, 11'b0};

endpackage

//--- issueControl.sv
// issue control for the fetch-to-decode boundary
// pcNop from the operand stalls and the branch shadow
// fetch-to-decode instruction register with NOP substitution
// checks on bubble insertion and on the shadow exemption
module issueControl
    import isaPkg::*, hazardPkg::*;
(
    input  logic         clk,
    input  logic         arstN,
    input  instWord      fetchInst,
    input  logic         stallA,
    input  logic         stallB,
    input  logic         honorsShadow,
    input  branchShadowT branchShadow,
    output logic         pcNop,
    output instWord      decodeInst
);

    logic shadowAny;

    // a branch anywhere from decode to writeback
    assign shadowAny = branchShadow.inD || branchShadow.inX ||
                       branchShadow.inM || branchShadow.inW;

    // hold the pc on a data stall or while a branch resolves
    assign pcNop = stallA || stallB || (honorsShadow && shadowAny);

    // fetch-to-decode register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            // nothing real issues out of reset
            decodeInst <= NopInst;
        end else if (pcNop) begin
            // bubble into decode
            decodeInst <= NopInst;
        end else begin
            decodeInst <= fetchInst;
        end
    end

    // a held fetch always shows up as a bubble next cycle
    property pBubbleAfterStall;
        @(posedge clk) disable iff (!arstN)
            pcNop |=> (decodeInst == NopInst);
    endproperty

    aBubbleAfterStall : assert property (pBubbleAfterStall)
        else $error("decodeInst not NOP the cycle after pcNop");

    // SIIC and RTI read no registers, so nothing may stall them
    property pExemptNeverStalls;
        @(posedge clk) disable iff (!arstN)
            !honorsShadow |-> !pcNop;
    endproperty

    aExemptNeverStalls : assert property (pExemptNeverStalls)
        else $error("pcNop raised for an opcode exempt from the shadow");

endmodule

//--- opcodeDecode.sv
// opcode classifier for the hazard unit
// maps the fetched opcode onto the registers it reads
// and flags whether it waits behind branches in flight
module opcodeDecode
    import isaPkg::*, hazardPkg::*;
(
    input  instWord    inst,
    output operandUseT opUse
);

    opcodeE op;

    // unlisted codes pass through the cast and hit the default
    assign op = opcodeE'(inst[OpcodeMsb:OpcodeLsb]);

    always_comb begin
        // nothing read, shadow honored
        opUse              = '0;
        opUse.honorsShadow = 1'b1;

        case (op)
            // stores, address in rs and data in rd
            opSt, opStu: begin
                opUse.readsRs     = 1'b1;
                opUse.readsSecond = 1'b1;
            end

            // register alu and bit ops
            opAluR, opBitR: begin
                opUse.readsRs     = 1'b1;
                opUse.readsSecond = 1'b1;
            end

            // set family
            opSeq, opSlt, opSle, opSco: begin
                opUse.readsRs     = 1'b1;
                opUse.readsSecond = 1'b1;
            end

            // branch family, condition on rs
            opBeqz, opBnez, opBltz, opBgez: begin
                opUse.readsRs = 1'b1;
            end

            // jump through register
            opJr, opJalr: begin
                opUse.readsRs = 1'b1;
            end

            // no register operands
            opHalt, opNop, opLbi: begin
                opUse.readsRs     = 1'b0;
                opUse.readsSecond = 1'b0;
            end

            // displacement jumps
            opJ, opJal: begin
                opUse.readsRs     = 1'b0;
                opUse.readsSecond = 1'b0;
            end

            // exception entry and return always pass
            opSiic, opRti: begin
                opUse.honorsShadow = 1'b0;
            end

            // anything else treated as an rs reader
            default: begin
                opUse.readsRs = 1'b1;
            end
        endcase
    end

endmodule

//--- operandHazard.sv
// hazard check for a single source operand
// compares the operand register against the D, X and M producers
// raises a stall for a memory-stage write or a load-use
// otherwise picks the forwarding path and data source
module operandHazard
    import isaPkg::*, hazardPkg::*;
(
    input  logic       used,
    input  regIdx      srcReg,
    input  stageWriteT stageD,
    input  stageWriteT stageX,
    input  stageWriteT stageM,
    input  wbSelE      wbSelD,
    input  wbSelE      wbSelX,
    output logic       stall,
    output fwdCtrlT    fwd
);

    logic matchD;
    logic matchX;
    logic matchM;
    logic loadUse;
    logic fwdTake;

    // producer writes the register this operand reads
    assign matchD = stageD.regWrt && (stageD.wrtReg == srcReg);
    assign matchX = stageX.regWrt && (stageX.wrtReg == srcReg);
    assign matchM = stageM.regWrt && (stageM.wrtReg == srcReg);

    // load result not ready until memory, no x2x path
    assign loadUse = matchD && (wbSelD == wbMem);

    // M stage write has no forward path, wait for the register file
    assign stall = used && (matchM || loadUse);

    // newest producer wins, D ahead of X
    assign fwdTake = used && ((matchD && !loadUse) || (matchX && !matchD));

    always_comb begin
        // idle control word
        fwd = '0;

        if (fwdTake) begin
            fwd.fwd = 1'b1;
            // D producer feeds x2x, X producer feeds m2x
            fwd.fromMem = !matchD;
            // data source follows the chosen producer
            fwd.src = matchD ? wbSelD : wbSelX;
        end
    end

endmodule

//--- tbHazardUnit.sv
// testbench top for the hazard unit
// clock, reset and seeded random stimulus
// DUT instance and the checker that compares its outputs
// closing summary with the pass or fail verdict
module tbHazardUnit
    import isaPkg::*, hazardPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NumCycles   = 2000;
    localparam int ResetCycles = 16;
    localparam int DoneTimeout = 20;
    localparam int Seed        = 62;

    logic         clk;
    logic         arstN;
    instWord      fetchInst;
    stageWriteT   stageD;
    stageWriteT   stageX;
    stageWriteT   stageM;
    wbSelE        wbSelD;
    wbSelE        wbSelX;
    branchShadowT branchShadow;
    logic         pcNop;
    fwdCtrlT      fwdA;
    fwdCtrlT      fwdB;
    instWord      decodeInst;

    int           errCount;
    int           checkCount;
    int           cycleCount;
    logic         timedOut;
    int           guard;

    // every listed opcode
    // random codes are mixed in separately
    logic [4:0]   opList [0:20];

    hazardUnit i_hazardUnit (
        .clk          (clk),
        .arstN        (arstN),
        .fetchInst    (fetchInst),
        .stageD       (stageD),
        .stageX       (stageX),
        .stageM       (stageM),
        .wbSelD       (wbSelD),
        .wbSelX       (wbSelX),
        .branchShadow (branchShadow),
        .pcNop        (pcNop),
        .fwdA         (fwdA),
        .fwdB         (fwdB),
        .decodeInst   (decodeInst)
    );

    hazardChecker iHazardChecker (
        .clk          (clk),
        .arstN        (arstN),
        .fetchInst    (fetchInst),
        .stageD       (stageD),
        .stageX       (stageX),
        .stageM       (stageM),
        .wbSelD       (wbSelD),
        .wbSelX       (wbSelX),
        .branchShadow (branchShadow),
        .pcNop        (pcNop),
        .fwdA         (fwdA),
        .fwdB         (fwdB),
        .decodeInst   (decodeInst),
        .errCount     (errCount),
        .checkCount   (checkCount),
        .cycleCount   (cycleCount)
    );

    // 8 ns period
    always #4 clk = ~clk;

    // one random producer
    // indices 0..3 so matches are common
    function automatic stageWriteT randomStage();
        stageWriteT s;
        s.regWrt = 1'($urandom % 2);
        s.wrtReg = regIdx'($urandom % 4);
        return s;
    endfunction

    // new fetch word and pipeline state
    task automatic driveRandom();
        logic [4:0] op;
        // mostly real opcodes with some arbitrary codes
        if (($urandom % 4) == 0) begin
            op = 5'($urandom);
        end else begin
            op = opList[$urandom % 21];
        end
        fetchInst              = 16'($urandom);
        fetchInst[15:11]       = op;
        fetchInst[10:8]        = regIdx'($urandom % 4);
        fetchInst[7:5]         = regIdx'($urandom % 4);
        stageD                 = randomStage();
        stageX                 = randomStage();
        stageM                 = randomStage();
        wbSelD                 = wbSelE'($urandom % 4);
        wbSelX                 = wbSelE'($urandom % 4);
        // roughly one in eight per shadow bit
        branchShadow.inD       = (($urandom % 8) == 0);
        branchShadow.inX       = (($urandom % 8) == 0);
        branchShadow.inM       = (($urandom % 8) == 0);
        branchShadow.inW       = (($urandom % 8) == 0);
    endtask

    initial begin
        opList = '{opHalt, opNop, opSiic, opRti, opJ, opJr, opJal, opJalr,
                   opBeqz, opBnez, opBltz, opBgez, opSt, opStu, opLbi,
                   opBitR, opAluR, opSeq, opSlt, opSle, opSco};
        timedOut     = 1'b0;
        clk          = 1'b0;
        arstN        = 1'b0;
        fetchInst    = NopInst;
        stageD       = '0;
        stageX       = '0;
        stageM       = '0;
        wbSelD       = wbSlbi;
        wbSelX       = wbSlbi;
        branchShadow = '0;
        void'($urandom(Seed));

        // reset for a fixed count of edges
        for (int i = 0; i < ResetCycles; i++) begin
            @(posedge clk);
        end
        #2;
        arstN = 1'b1;

        // new inputs shortly after every rising edge
        for (int i = 0; i < NumCycles; i++) begin
            @(posedge clk);
            #2;
            driveRandom();
        end

        // last issue still has to reach decode and be compared there
        guard = 0;
        while (cycleCount < NumCycles + 2 && guard < DoneTimeout) begin
            @(posedge clk);
            guard++;
        end
        if (cycleCount < NumCycles + 2) begin
            timedOut = 1'b1;
            $display("checker did not finish %0d cycles within %0d extra clocks",
                     NumCycles + 2, DoneTimeout);
        end

        $display("checks %0d errors %0d", checkCount, errCount);
        if (timedOut || errCount != 0) begin
            $display("TESTS FAILED");
        end else begin
            $display("TESTS PASSED");
        end
        $finish;
    end

endmodule

//--- verilog.f
isaPkg.sv
hazardPkg.sv
opcodeDecode.sv
operandHazard.sv
issueControl.sv
hazardUnit.sv
hazardChecker.sv
tbHazardUnit.sv
